// ==== logic/pipeConfig_config.svh ====
// Build-time constants for the five-stage move/add pipeline.
// Include this header wherever a width, a depth, an opcode position or an
// arithmetic constant is needed. The package builds its vector types from it.
`ifndef PIPE_CONFIG_CONFIG_SVH
`define PIPE_CONFIG_CONFIG_SVH

// Register file and operand sizes
`define DATA_WIDTH      16
`define REG_COUNT       16
`define REG_ID_WIDTH    4

// Instruction word and fetch addressing
`define INSTR_WIDTH     32
`define PC_WIDTH        8
`define IMEM_DEPTH      64
`define IMEM_ADDR_WIDTH 6

// One-hot opcode bit positions inside the instruction word
`define OP_MOV_BIT      31
`define OP_SUB3_BIT     30
`define OP_ADD4_BIT     29
`define OP_ADD1_BIT     28

// Positions of the same flags once packed into a 4-bit flag vector
`define OPF_WIDTH       4
`define OPF_MOV         3
`define OPF_SUB3        2
`define OPF_ADD4        1
`define OPF_ADD1        0

// Register fields of the instruction word
`define DEST_LSB        4
`define SRC_LSB         0

// Constants applied by the two execute stages
`define SUB_AMOUNT      3
`define ADD_AMOUNT      4

`endif

// ==== logic/pipePkg.sv ====
// Shared vector types for the five-stage move/add pipeline.
// Every stage and the top level take these types by a wildcard import,
// so a width change in the configuration header reaches all of them at once.

`include "pipeConfig_config.svh"

package pipePkg;

	// --------------------------------------------------
	// Datapath values
	// --------------------------------------------------

	// One register value, also the operand width of both adders
	typedef logic [`DATA_WIDTH-1:0] dataT;

	// Register number as carried in the destination and source fields
	typedef logic [`REG_ID_WIDTH-1:0] regIdT;

	// --------------------------------------------------
	// Instruction side
	// --------------------------------------------------

	// Full instruction word as stored in instruction memory
	typedef logic [`INSTR_WIDTH-1:0] instrT;

	// Program counter, wider than the memory so only its low bits address it
	typedef logic [`PC_WIDTH-1:0] pcT;

	// Instruction memory word address, used by the load port and by fetch
	typedef logic [`IMEM_ADDR_WIDTH-1:0] imemAddrT;

	// --------------------------------------------------
	// Control
	// --------------------------------------------------

	// One-hot opcode flags, MOV in the top bit down to ADD1 in the bottom bit
	// All zero marks a NOP or a bubble, which never writes the register file
	typedef logic [`OPF_WIDTH-1:0] opFlagsT;

endpackage

// ==== logic/fetchStage.sv ====
// Fetch stage of the move/add pipeline.
// Holds the instruction memory with its load port and the program counter,
// and drives the fetch/decode register that decode works from.
// The PC and the fetch/decode register hold while decode stalls, and fetch
// feeds bubbles while run is low.

`timescale 1ns/1ps

`include "pipeConfig_config.svh"

module fetchStage
	import pipePkg::*;
(
	input  logic     CLK,
	input  logic     RSTB,
	input  logic     stall,
	input  logic     run,
	input  logic     imemLoadEn,
	input  imemAddrT imemLoadAddr,
	input  instrT    imemLoadData,
	output instrT    idInstr
);

	// --------------------------------------------------
	// Instruction memory
	// --------------------------------------------------

	// 64 words, written one per cycle through the load port
	instrT imem [`IMEM_DEPTH];

	// Program counter and the memory address taken from its low bits
	pcT       pc;
	imemAddrT fetchAddr;

	// The PC wraps through the memory as its low six bits roll over
	assign fetchAddr = pc[`IMEM_ADDR_WIDTH-1:0];

	// The load port is independent of reset, so a program can be written
	// while the rest of the pipeline is still held
	always_ff @(posedge CLK)
	begin
		if (imemLoadEn)
		begin
			imem[imemLoadAddr] <= imemLoadData;
		end
	end

	// --------------------------------------------------
	// PC and fetch/decode register
	// --------------------------------------------------

	always_ff @(posedge CLK or negedge RSTB)
	begin
		if (!RSTB)
		begin
			pc      <= '0;
			// An all-zero word has no opcode flag set, so decode starts on a bubble
			idInstr <= '0;
		end
		else if (!stall)
		begin
			if (run)
			begin
				// Memory is read combinationally at the PC and captured here
				idInstr <= imem[fetchAddr];
				pc      <= pc + pcT'(1);
			end
			else
			begin
				// Not running yet, so keep the PC and push a NOP into decode
				idInstr <= '0;
			end
		end
		// While stalled both the PC and the decode instruction stay put
	end

endmodule

// ==== logic/decodeStage.sv ====
// Decode stage of the move/add pipeline.
// Splits the instruction into flags and register fields, reads the register
// file with a same-cycle bypass from writeback, compares the source against
// the destinations of the two instructions ahead and detects the one
// hazard forwarding cannot cover. Drives the decode/subtract register.

`timescale 1ns/1ps

`include "pipeConfig_config.svh"

module decodeStage
	import pipePkg::*;
(
	input  logic    CLK,
	input  logic    RSTB,
	input  instrT   idInstr,
	input  regIdT   ex2Dest,
	input  logic    wbEn,
	input  regIdT   wbDest,
	input  dataT    wbData,
	output logic    stall,
	output dataT    ex1Data,
	output regIdT   ex1Dest,
	output opFlagsT ex1Ops,
	output logic    ex1MatchEx1,
	output logic    ex1MatchEx2
);

	// --------------------------------------------------
	// Field decode
	// --------------------------------------------------

	opFlagsT idOps;
	regIdT   idDest;
	regIdT   idSrc;
	dataT    idSrcData;
	logic    matchEx1;
	logic    matchEx2;

	// Register file, cleared by reset and written at the clock edge
	dataT regFile [`REG_COUNT];

	// Gather the flags in the MOV, SUB3, ADD4, ADD1 order of opFlagsT
	assign idOps = {idInstr[`OP_MOV_BIT], idInstr[`OP_SUB3_BIT],
		idInstr[`OP_ADD4_BIT], idInstr[`OP_ADD1_BIT]};

	assign idDest = idInstr[`DEST_LSB +: `REG_ID_WIDTH];
	assign idSrc  = idInstr[`SRC_LSB +: `REG_ID_WIDTH];

	// A write landing this cycle on the register being read is returned
	// directly, which gives the distance-three dependence its value
	assign idSrcData = (wbEn && (wbDest == idSrc)) ? wbData : regFile[idSrc];

	// --------------------------------------------------
	// Compare station and stall
	// --------------------------------------------------

	// Against the instruction now in subtract, which will be one stage ahead
	assign matchEx1 = (idSrc == ex1Dest);

	// Against the instruction now in add, which will be two stages ahead
	assign matchEx2 = (idSrc == ex2Dest);

	// SUB3 and ADD1 need their operand at the start of subtract, but an ADD4
	// or ADD1 directly ahead only has its result at the end of add
	// That gap is one cycle, so the consumer waits once in decode
	assign stall = matchEx1
		&& (idOps[`OPF_SUB3] || idOps[`OPF_ADD1])
		&& (ex1Ops[`OPF_ADD4] || ex1Ops[`OPF_ADD1]);

	// --------------------------------------------------
	// Register file write
	// --------------------------------------------------

	always_ff @(posedge CLK or negedge RSTB)
	begin
		if (!RSTB)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
			begin
				regFile[i] <= '0;
			end
		end
		else if (wbEn)
		begin
			regFile[wbDest] <= wbData;
		end
	end

	// --------------------------------------------------
	// Decode/subtract register
	// --------------------------------------------------

	always_ff @(posedge CLK or negedge RSTB)
	begin
		if (!RSTB)
		begin
			ex1Ops      <= '0;
			ex1Dest     <= '0;
			ex1MatchEx1 <= 1'b0;
			ex1MatchEx2 <= 1'b0;
		end
		else
		begin
			// A stalled instruction leaves a bubble behind it in subtract
			ex1Ops      <= stall ? opFlagsT'(0) : idOps;
			ex1Dest     <= idDest;
			ex1MatchEx1 <= matchEx1;
			ex1MatchEx2 <= matchEx2;
		end
	end

	// Operand value only matters while flags are set
	always_ff @(posedge CLK)
	begin
		ex1Data <= idSrcData;
	end

endmodule

// ==== logic/subtractStage.sv ====
// Subtract stage of the move/add pipeline.
// Picks the operand from the add stage, from writeback or from the
// register file read, subtracts the constant for SUB3 and ADD1 and passes
// the value unchanged for MOV and ADD4. Drives the subtract/add register.

`timescale 1ns/1ps

`include "pipeConfig_config.svh"

module subtractStage
	import pipePkg::*;
(
	input  logic    CLK,
	input  logic    RSTB,
	input  dataT    ex1Data,
	input  regIdT   ex1Dest,
	input  opFlagsT ex1Ops,
	input  logic    ex1MatchEx1,
	input  logic    ex1MatchEx2,
	input  dataT    ex2Forward,
	input  logic    wbEn,
	input  dataT    wbData,
	output dataT    ex2Data,
	output regIdT   ex2Dest,
	output opFlagsT ex2Ops,
	output logic    ex2MatchEx1
);

	// --------------------------------------------------
	// Operand selection
	// --------------------------------------------------

	logic fwdFromEx2;
	logic fwdFromWb;
	dataT subIn;
	dataT subOut;
	logic skipSub;

	// MOV and SUB3 already hold their final value in the add stage
	// They are also the newer producer, so they win over writeback
	assign fwdFromEx2 = ex1MatchEx1 && (ex2Ops[`OPF_SUB3] || ex2Ops[`OPF_MOV]);
	assign fwdFromWb  = ex1MatchEx2 && wbEn;

	always_comb
	begin
		if (fwdFromEx2)
		begin
			subIn = ex2Forward;
		end
		else if (fwdFromWb)
		begin
			subIn = wbData;
		end
		else
		begin
			subIn = ex1Data;
		end
	end

	// --------------------------------------------------
	// Subtractor and skip mux
	// --------------------------------------------------

	// Wraps modulo 2^16, so 0 becomes 65533
	assign subOut = subIn - dataT'(`SUB_AMOUNT);

	// ADD1 is SUB3 followed by ADD4, so it also goes through here
	assign skipSub = !(ex1Ops[`OPF_SUB3] || ex1Ops[`OPF_ADD1]);

	always_ff @(posedge CLK or negedge RSTB)
	begin
		if (!RSTB)
		begin
			ex2Ops      <= '0;
			ex2Dest     <= '0;
			ex2MatchEx1 <= 1'b0;
		end
		else
		begin
			ex2Ops      <= ex1Ops;
			ex2Dest     <= ex1Dest;
			ex2MatchEx1 <= ex1MatchEx1;
		end
	end

	always_ff @(posedge CLK)
	begin
		ex2Data <= skipSub ? subIn : subOut;
	end

endmodule

// ==== logic/addStage.sv ====
// Add stage of the move/add pipeline.
// Takes a writeback value for MOV and ADD4 when the instruction directly
// ahead produced the source, adds the constant for ADD4 and ADD1 and
// registers the final result for writeback. Its adder input is also the
// value handed back to subtract for a MOV or SUB3 sitting here.

`timescale 1ns/1ps

`include "pipeConfig_config.svh"

module addStage
	import pipePkg::*;
(
	input  logic    CLK,
	input  logic    RSTB,
	input  dataT    ex2Data,
	input  regIdT   ex2Dest,
	input  opFlagsT ex2Ops,
	input  logic    ex2MatchEx1,
	output dataT    ex2Forward,
	output logic    wbEn,
	output regIdT   wbDest,
	output dataT    wbData
);

	// --------------------------------------------------
	// Forwarding and adder
	// --------------------------------------------------

	logic fwdFromWb;
	dataT addIn;
	dataT addOut;
	logic skipAdd;

	// SUB3 and ADD1 got their operand in subtract, only MOV and ADD4 still
	// need help from the instruction now retiring
	assign fwdFromWb = ex2MatchEx1 && (ex2Ops[`OPF_ADD4] || ex2Ops[`OPF_MOV]) && wbEn;

	assign addIn      = fwdFromWb ? wbData : ex2Data;
	assign ex2Forward = addIn;

	assign addOut  = addIn + dataT'(`ADD_AMOUNT);
	assign skipAdd = !(ex2Ops[`OPF_ADD4] || ex2Ops[`OPF_ADD1]);

	// --------------------------------------------------
	// Writeback register
	// --------------------------------------------------

	always_ff @(posedge CLK or negedge RSTB)
	begin
		if (!RSTB)
		begin
			wbEn   <= 1'b0;
			wbDest <= '0;
		end
		else
		begin
			// Any set flag is a real instruction, bubbles and NOPs write nothing
			wbEn   <= |ex2Ops;
			wbDest <= ex2Dest;
		end
	end

	always_ff @(posedge CLK)
	begin
		wbData <= skipAdd ? addIn : addOut;
	end

endmodule

// ==== logic/movePipeTop.sv ====
// Top level of the five-stage move/add pipeline.
// Chains fetch, decode, subtract and add, with writeback folded into the
// register file of decode. Load the program through the memory port with
// run low, then raise run. Every retiring instruction that writes a
// register pulses commitEn for one cycle with its register and value.

`timescale 1ns/1ps

module movePipeTop
	import pipePkg::*;
(
	input  logic     CLK,
	input  logic     RSTB,
	input  logic     imemLoadEn,
	input  imemAddrT imemLoadAddr,
	input  instrT    imemLoadData,
	input  logic     run,
	output logic     commitEn,
	output regIdT    commitReg,
	output dataT     commitData
);

	// Fetch to decode
	logic    stall;
	instrT   idInstr;

	// Decode to subtract
	dataT    ex1Data;
	regIdT   ex1Dest;
	opFlagsT ex1Ops;
	logic    ex1MatchEx1;
	logic    ex1MatchEx2;

	// Subtract to add, and the add stage value handed back
	dataT    ex2Data;
	regIdT   ex2Dest;
	opFlagsT ex2Ops;
	logic    ex2MatchEx1;
	dataT    ex2Forward;

	// Writeback, shared by the register file, forwarding and the commit port
	logic    wbEn;
	regIdT   wbDest;
	dataT    wbData;

	fetchStage fetch_i (
		.CLK(CLK), .RSTB(RSTB), .stall(stall), .run(run),
		.imemLoadEn(imemLoadEn), .imemLoadAddr(imemLoadAddr),
		.imemLoadData(imemLoadData), .idInstr(idInstr)
	);

	decodeStage decode_i (
		.CLK(CLK), .RSTB(RSTB), .idInstr(idInstr), .ex2Dest(ex2Dest),
		.wbEn(wbEn), .wbDest(wbDest), .wbData(wbData), .stall(stall),
		.ex1Data(ex1Data), .ex1Dest(ex1Dest), .ex1Ops(ex1Ops),
		.ex1MatchEx1(ex1MatchEx1), .ex1MatchEx2(ex1MatchEx2)
	);

	subtractStage subtract_i (
		.CLK(CLK), .RSTB(RSTB), .ex1Data(ex1Data), .ex1Dest(ex1Dest),
		.ex1Ops(ex1Ops), .ex1MatchEx1(ex1MatchEx1), .ex1MatchEx2(ex1MatchEx2),
		.ex2Forward(ex2Forward), .wbEn(wbEn), .wbData(wbData),
		.ex2Data(ex2Data), .ex2Dest(ex2Dest), .ex2Ops(ex2Ops),
		.ex2MatchEx1(ex2MatchEx1)
	);

	addStage add_i (
		.CLK(CLK), .RSTB(RSTB), .ex2Data(ex2Data), .ex2Dest(ex2Dest),
		.ex2Ops(ex2Ops), .ex2MatchEx1(ex2MatchEx1), .ex2Forward(ex2Forward),
		.wbEn(wbEn), .wbDest(wbDest), .wbData(wbData)
	);

	// The commit port is the register write itself
	assign commitEn   = wbEn;
	assign commitReg  = wbDest;
	assign commitData = wbData;

endmodule

// ==== tests/pipeTb.sv ====
// Testbench for the five-stage move/add pipeline.
// Loads a directed and random program through the memory port with run low,
// raises run and checks every commit against an in-order register model.
// Assertions check commit values, order and count, and the stall spacing.

`timescale 1ns/1ps

`include "pipeConfig_config.svh"

module pipeTb
	import pipePkg::*;
();

	// --------------------------------------------------
	// Constants and DUT signals
	// --------------------------------------------------

	localparam int progLen = 40;
	// 40 instructions at two cycles each at worst, four cycles of fill, and margin
	localparam int timeoutCycles = 200;
	localparam int quietCycles = 10;

	// Opcode flags in MOV, SUB3, ADD4, ADD1 order
	localparam opFlagsT opNop  = 4'b0000;
	localparam opFlagsT opMov  = 4'b1000;
	localparam opFlagsT opSub3 = 4'b0100;
	localparam opFlagsT opAdd4 = 4'b0010;
	localparam opFlagsT opAdd1 = 4'b0001;

	logic     CLK;
	logic     RSTB;
	logic     imemLoadEn;
	imemAddrT imemLoadAddr;
	instrT    imemLoadData;
	logic     run;
	logic     commitEn;
	regIdT    commitReg;
	dataT     commitData;

	// Program image and the in-order model of the register file
	instrT   prog [`IMEM_DEPTH];
	dataT    modelRegs [`REG_COUNT];
	int      progSlot;
	opFlagsT prevOps;
	regIdT   prevDest;
	integer  seed;

	// Expected commits, with 2 in expGap where a stall must space the pair
	regIdT expReg [$];
	dataT  expData [$];
	int    expGap [$];

	int cycleCount;
	int lastCommitCycle;
	int commitCount;

	movePipeTop dut_i (
		.CLK(CLK), .RSTB(RSTB), .imemLoadEn(imemLoadEn),
		.imemLoadAddr(imemLoadAddr), .imemLoadData(imemLoadData), .run(run),
		.commitEn(commitEn), .commitReg(commitReg), .commitData(commitData)
	);

	initial
	begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	// --------------------------------------------------
	// Program generation and reference model
	// --------------------------------------------------

	function automatic instrT encode(opFlagsT ops, regIdT dest, regIdT src);
		instrT word;
		word = '0;
		word[`OP_MOV_BIT]  = ops[3];
		word[`OP_SUB3_BIT] = ops[2];
		word[`OP_ADD4_BIT] = ops[1];
		word[`OP_ADD1_BIT] = ops[0];
		word[`DEST_LSB +: `REG_ID_WIDTH] = dest;
		word[`SRC_LSB +: `REG_ID_WIDTH]  = src;
		return word;
	endfunction

	// Appends one instruction and executes it on the model in program order
	task addInstr(input opFlagsT ops, input regIdT dest, input regIdT src);
		dataT result;
		int   gap;
		prog[progSlot] = encode(ops, dest, src);
		progSlot = progSlot + 1;
		gap = 0;
		if (ops != opNop)
		begin
			case (ops)
				opMov:   result = modelRegs[src];
				opSub3:  result = modelRegs[src] - dataT'(3);
				opAdd4:  result = modelRegs[src] + dataT'(4);
				default: result = modelRegs[src] + dataT'(1);
			endcase
			modelRegs[dest] = result;
			// SUB3 or ADD1 right behind an ADD4 or ADD1 writing its source waits once
			if ((ops == opSub3 || ops == opAdd1) && (prevOps == opAdd4 || prevOps == opAdd1)
				&& src == prevDest)
			begin
				gap = 2;
			end
			expReg.push_back(dest);
			expData.push_back(result);
			expGap.push_back(gap);
		end
		prevOps  = ops;
		prevDest = dest;
	endtask

	task buildProgram;
		int      r;
		opFlagsT ops;
		for (int i = 0; i < `REG_COUNT; i++)
		begin
			modelRegs[i] = '0;
		end
		progSlot = 0;
		prevOps  = opNop;
		prevDest = '0;
		// Each opcode on independent registers with SUB3 wrapping 0 to 65533
		addInstr(opAdd4, 4'd1, 4'd0);
		addInstr(opSub3, 4'd2, 4'd0);
		addInstr(opAdd1, 4'd3, 4'd0);
		addInstr(opNop, 4'd0, 4'd0);
		addInstr(opMov, 4'd4, 4'd1);
		// Consumers directly after MOV, SUB3, ADD1 and ADD4 producers
		addInstr(opMov, 4'd5, 4'd2);
		addInstr(opSub3, 4'd6, 4'd5);
		addInstr(opAdd1, 4'd7, 4'd6);
		addInstr(opAdd4, 4'd8, 4'd7);
		addInstr(opAdd4, 4'd9, 4'd8);
		addInstr(opMov, 4'd10, 4'd9);
		// Stall pairs with the last two back to back
		addInstr(opAdd4, 4'd11, 4'd3);
		addInstr(opSub3, 4'd11, 4'd11);
		addInstr(opAdd1, 4'd12, 4'd4);
		addInstr(opAdd1, 4'd12, 4'd12);
		addInstr(opSub3, 4'd13, 4'd12);
		addInstr(opAdd1, 4'd13, 4'd13);
		// Distance two across a NOP and across a real instruction, then distance three
		addInstr(opAdd4, 4'd14, 4'd1);
		addInstr(opNop, 4'd0, 4'd0);
		addInstr(opSub3, 4'd15, 4'd14);
		addInstr(opAdd4, 4'd2, 4'd15);
		addInstr(opMov, 4'd3, 4'd10);
		addInstr(opAdd1, 4'd4, 4'd2);
		addInstr(opMov, 4'd5, 4'd9);
		addInstr(opMov, 4'd6, 4'd13);
		addInstr(opSub3, 4'd7, 4'd4);
		// Random tail over r0 to r3 so that dependences pile up
		while (progSlot < progLen)
		begin
			r = $random(seed);
			case (r[2:0])
				3'd0:         ops = opNop;
				3'd1, 3'd2:   ops = opMov;
				3'd3, 3'd4:   ops = opSub3;
				3'd5, 3'd6:   ops = opAdd4;
				default:      ops = opAdd1;
			endcase
			addInstr(ops, {2'b00, r[5:4]}, {2'b00, r[9:8]});
		end
		// NOP filler up to the last memory word
		while (progSlot < `IMEM_DEPTH)
		begin
			addInstr(opNop, 4'd0, 4'd0);
		end
	endtask

	// --------------------------------------------------
	// Checking
	// --------------------------------------------------

	task abortRun(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task checkCommit;
		regIdT wantReg;
		dataT  wantData;
		int    wantGap;
		assert (expReg.size() > 0)
		else abortRun($sformatf("ERROR at %0d ns: extra commit r%0d = %0d", $time,
			commitReg, commitData));
		wantReg  = expReg.pop_front();
		wantData = expData.pop_front();
		wantGap  = expGap.pop_front();
		assert (commitReg == wantReg && commitData == wantData)
		else abortRun($sformatf("ERROR at %0d ns: commit r%0d = %0d, expected r%0d = %0d",
			$time, commitReg, commitData, wantReg, wantData));
		if (wantGap > 0)
		begin
			assert (cycleCount - lastCommitCycle == wantGap)
			else abortRun($sformatf("ERROR at %0d ns: stalled commit came %0d cycles late",
				$time, cycleCount - lastCommitCycle));
		end
		lastCommitCycle = cycleCount;
		commitCount = commitCount + 1;
	endtask

	// Outputs settle after the rising edge, so they are sampled on the falling one
	always @(negedge CLK)
	begin
		if (run)
		begin
			cycleCount = cycleCount + 1;
			if (cycleCount > timeoutCycles)
			begin
				abortRun("Timeout: the program did not drain within 200 cycles of run");
			end
		end
		if (RSTB)
		begin
			assert (run || !commitEn)
			else abortRun($sformatf("ERROR at %0d ns: commitEn high while run is low", $time));
			if (commitEn)
			begin
				checkCommit();
			end
		end
	end

	// --------------------------------------------------
	// Stimulus
	// --------------------------------------------------

	initial
	begin
		RSTB = 1'b0;
		run = 1'b0;
		imemLoadEn = 1'b0;
		imemLoadAddr = '0;
		imemLoadData = '0;
		seed = 74;
		cycleCount = 0;
		lastCommitCycle = 0;
		commitCount = 0;
		buildProgram();
		repeat (4) @(posedge CLK);
		#1 RSTB = 1'b1;
		// One word per cycle, pipeline idle because run stays low
		for (int a = 0; a < `IMEM_DEPTH; a++)
		begin
			@(posedge CLK);
			#1;
			imemLoadEn = 1'b1;
			imemLoadAddr = imemAddrT'(a);
			imemLoadData = prog[a];
		end
		@(posedge CLK);
		#1 imemLoadEn = 1'b0;
		@(posedge CLK);
		#1 run = 1'b1;
		// The monitor pops one entry per commit and the timeout covers a stuck pipe
		while (expReg.size() > 0)
		begin
			@(posedge CLK);
		end
		// Any commit in this window has no queue entry and stops the run
		repeat (quietCycles) @(posedge CLK);
		$display("Checked %0d commits", commitCount);
		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+logic
logic/pipePkg.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/subtractStage.sv
logic/addStage.sv
logic/movePipeTop.sv
tests/pipeTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the pipeline testbench with Verilator and runs it.
# The exit status is the simulator's, so a failed check fails this script.
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
	-f compile.f \
	--top-module pipeTb \
	-o pipeTb

./obj_dir/pipeTb
